// ==== design/route_core_cfg.svh ====
/* Sizes of the forwarding core. RC_NETH must stay 4 while port_idx_t is 2 bits wide.
   MAC fields are located in the first beat of a frame, most significant byte first. */
`ifndef ROUTE_CORE_CFG_SVH
`define ROUTE_CORE_CFG_SVH

// Number of switch ports
`define RC_NETH 4

// Bits per beat on both the receive and the transmit side
`define RC_BEATW 128

// Bits in one MAC address
`define RC_MACW 48

// Log2 of the learned table depth, 8 entries
`define RC_LGTBL 3

// Destination MAC sits in bits 127..80 of the first beat
`define RC_DST_LSB 80
// Source MAC follows it in bits 79..32
`define RC_SRC_LSB 32

`endif

// ==== design/route_core_pkg.sv ====
/* Vector types and FSM encoding shared by the forwarding core. */
`default_nettype none

`include "route_core_cfg.svh"

package route_core_pkg;

	// One beat of frame data
	typedef logic [`RC_BEATW-1:0] beat_t;

	// A MAC address
	typedef logic [`RC_MACW-1:0] mac_t;

	// One bit per port, for masks, grants, valid and ready vectors
	typedef logic [`RC_NETH-1:0] port_mask_t;

	// Number of one port
	typedef logic [1:0] port_idx_t;

	// Index into the learned table
	typedef logic [`RC_LGTBL-1:0] tbl_idx_t;

	// Forwarding FSM: wait for a port, resolve it, stream the frame
	typedef enum logic [1:0] {FWD_IDLE, FWD_LOOKUP, FWD_PASS} fwd_state_t;

endpackage

`default_nettype wire

// ==== design/rx_port_arb.sv ====
/* Grants one receive port per frame in round-robin order after the last served port.
   Before a grant the mux shows the candidate port so its first beat can be looked up. */
`timescale 1ns/1ps
`default_nettype none

`include "route_core_cfg.svh"

module rx_port_arb
	import route_core_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire port_mask_t i_rx_valid,
	output port_mask_t o_rx_ready,
	input  wire beat_t i_rx_data [`RC_NETH],
	input  wire port_mask_t i_rx_last,
	input  wire        i_grant_take,
	input  wire        i_grant_done,
	input  wire        i_fwd_ready,
	output logic       o_req,
	output logic       o_valid,
	output logic       o_last,
	output beat_t      o_data,
	output port_idx_t  o_src
);

	port_mask_t grant;
	// Last served port and the granted port while a grant is held
	port_idx_t  last_q;
	port_idx_t  pick;
	port_idx_t  cand;
	port_idx_t  sel;
	logic       granted;

	// Search starts one past the last served port and wraps
	always_comb
	begin
		pick = last_q;
		for (int k = `RC_NETH; k >= 1; k--)
		begin
			cand = port_idx_t'(last_q + k);
			if (i_rx_valid[cand])
				pick = cand;
		end
	end

	assign granted = |grant;
	assign sel     = granted ? last_q : pick;
	assign o_req   = (|i_rx_valid) & ~granted;

	// Beat mux with valid raised only once the grant is latched
	assign o_data     = i_rx_data[sel];
	assign o_last     = i_rx_last[sel];
	assign o_src      = sel;
	assign o_valid    = |(grant & i_rx_valid);
	assign o_rx_ready = grant & {`RC_NETH{i_fwd_ready}};

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			grant  <= '0;
			// Port 0 is searched first after reset
			last_q <= port_idx_t'(`RC_NETH - 1);
		end
		else if (i_grant_done)
			grant <= '0;
		else if (i_grant_take)
		begin
			grant  <= port_mask_t'(1) << pick;
			last_q <= pick;
		end
	end

	// Never more than one port owns the path
	a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(grant));

endmodule

`default_nettype wire

// ==== design/mac_route_table.sv ====
/* Eight learned entries with no aging; a new MAC replaces entries in round-robin order.
   A lookup sees the table as it was before the learn of the same request. */
`timescale 1ns/1ps
`default_nettype none

`include "route_core_cfg.svh"

module mac_route_table
	import route_core_pkg::*;
(
	input  wire       i_clk,
	input  wire       i_rst_n,
	input  wire       i_lkup,
	input  wire mac_t i_src_mac,
	input  wire mac_t i_dst_mac,
	input  wire port_idx_t i_src,
	output logic      o_hit,
	output port_idx_t o_port
);

	localparam int NTBL = 1 << `RC_LGTBL;

	////////////////////////////////////////////////////////////
	// Table storage
	////////////////////////////////////////////////////////////
	logic [NTBL-1:0] tbl_vld;
	mac_t            tbl_mac  [NTBL];
	port_idx_t       tbl_port [NTBL];
	// Next entry to overwrite with an unknown source
	tbl_idx_t        rep_ptr;

	logic      dst_hit;
	port_idx_t dst_port;
	logic      src_hit;
	tbl_idx_t  src_idx;

	// Parallel match of both MACs against every entry
	always_comb
	begin
		dst_hit  = 1'b0;
		dst_port = '0;
		src_hit  = 1'b0;
		src_idx  = '0;
		for (int e = 0; e < NTBL; e++)
		begin
			if (tbl_vld[e] && tbl_mac[e] == i_dst_mac)
			begin
				dst_hit  = 1'b1;
				dst_port = tbl_port[e];
			end
			if (tbl_vld[e] && tbl_mac[e] == i_src_mac)
			begin
				src_hit = 1'b1;
				src_idx = tbl_idx_t'(e);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Learn and registered result
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			tbl_vld <= '0;
			rep_ptr <= '0;
			o_hit   <= 1'b0;
		end
		else
		begin
			o_hit <= i_lkup & dst_hit;
			// New source claims the entry under the pointer
			if (i_lkup && !src_hit)
			begin
				tbl_vld[rep_ptr] <= 1'b1;
				rep_ptr          <= rep_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_lkup)
		begin
			o_port <= dst_port;
			// Known source moves in place, station may have changed port
			if (src_hit)
				tbl_port[src_idx] <= i_src;
			else
			begin
				tbl_mac[rep_ptr]  <= i_src_mac;
				tbl_port[rep_ptr] <= i_src;
			end
		end
	end

	// Result is strictly one cycle behind its request
	a_hit_after_lkup: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_hit |-> $past(i_lkup));

endmodule

`default_nettype wire

// ==== design/fwd_ctrl.sv ====
/* One frame at a time. The mask is valid from the lookup cycle, so the first beat
   may already leave then; a frame back to its own port is accepted and dropped. */
`timescale 1ns/1ps
`default_nettype none

`include "route_core_cfg.svh"

module fwd_ctrl
	import route_core_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_req,
	input  wire        i_beat_valid,
	input  wire        i_beat_last,
	input  wire        i_beat_take,
	input  wire beat_t i_first_data,
	input  wire port_idx_t i_src,
	input  wire        i_hit,
	input  wire port_idx_t i_port,
	output logic       o_grant_take,
	output logic       o_grant_done,
	output logic       o_lkup,
	output mac_t       o_src_mac,
	output mac_t       o_dst_mac,
	output port_mask_t o_mask
);

	fwd_state_t state;
	port_mask_t mask_q;
	port_mask_t mask_nx;
	logic       bcast_q;
	logic       take;

	// MAC fields of the first beat
	assign o_dst_mac = i_first_data[`RC_DST_LSB +: `RC_MACW];
	assign o_src_mac = i_first_data[`RC_SRC_LSB +: `RC_MACW];

	// Grant and lookup start together
	assign o_grant_take = (state == FWD_IDLE) & i_req;
	assign o_lkup       = o_grant_take;

	assign take         = i_beat_valid & i_beat_take;
	assign o_grant_done = (state != FWD_IDLE) & take & i_beat_last;

	// Flood on broadcast or miss; a hit on the source itself sends nowhere
	always_comb
	begin
		mask_nx = ~(port_mask_t'(1) << i_src);
		if (!bcast_q && i_hit)
		begin
			if (i_port == i_src)
				mask_nx = '0;
			else
				mask_nx = port_mask_t'(1) << i_port;
		end
	end

	assign o_mask = (state == FWD_LOOKUP) ? mask_nx : mask_q;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state   <= FWD_IDLE;
			mask_q  <= '0;
			bcast_q <= 1'b0;
		end
		else
		begin
			case (state)
				FWD_IDLE:
				begin
					if (i_req)
					begin
						bcast_q <= &o_dst_mac;
						state   <= FWD_LOOKUP;
					end
				end
				FWD_LOOKUP:
				begin
					mask_q <= mask_nx;
					// Single-beat frame may finish here
					state  <= o_grant_done ? FWD_IDLE : FWD_PASS;
				end
				default:
				begin
					if (o_grant_done)
						state <= FWD_IDLE;
				end
			endcase
		end
	end

	// Source port comes from the arbiter, mask from the table result
	a_no_echo: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state == FWD_PASS) |-> !o_mask[i_src]);

endmodule

`default_nettype wire

// ==== design/tx_fanout.sv ====
/* One-beat register shared by all transmit ports; data and last are common to all.
   The next beat loads in the cycle the last owed port takes the current one. */
`timescale 1ns/1ps
`default_nettype none

module tx_fanout
	import route_core_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_valid,
	input  wire        i_last,
	input  wire beat_t i_data,
	input  wire port_mask_t i_mask,
	output logic       o_ready,
	output port_mask_t o_tx_valid,
	output beat_t      o_tx_data,
	output logic       o_tx_last,
	input  wire port_mask_t i_tx_ready
);

	// Ports still owed the held beat
	port_mask_t pend;
	// Mask the held beat was loaded with
	port_mask_t mask_q;
	beat_t      data_q;
	logic       last_q;
	logic       load;

	// Register empty or every owed port takes the beat now
	assign o_ready = ((pend & ~i_tx_ready) == '0);
	assign load    = i_valid & o_ready;

	assign o_tx_valid = pend;
	assign o_tx_data  = data_q;
	assign o_tx_last  = last_q;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			pend <= '0;
		else if (load)
			// An empty mask owes no port and drops the beat
			pend <= i_mask;
		else
			pend <= pend & ~i_tx_ready;
	end

	always_ff @(posedge i_clk)
	begin
		if (load)
		begin
			data_q <= i_data;
			last_q <= i_last;
			mask_q <= i_mask;
		end
	end

	// Owed ports never leave the mask of the held beat
	a_pend_subset: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(pend & ~mask_q) == '0);

endmodule

`default_nettype wire

// ==== design/route_core.sv ====
/* Four-port forwarding core with one shared path: one frame moves at a time.
   Transmit data and last are common; o_tx_valid selects the ports that take them. */
`timescale 1ns/1ps
`default_nettype none

`include "route_core_cfg.svh"

module route_core
	import route_core_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire port_mask_t i_rx_valid,
	output port_mask_t o_rx_ready,
	input  wire beat_t i_rx_data [`RC_NETH],
	input  wire port_mask_t i_rx_last,
	output port_mask_t o_tx_valid,
	input  wire port_mask_t i_tx_ready,
	output beat_t      o_tx_data,
	output logic       o_tx_last
);

	// Arbiter to FSM handshake
	logic       req;
	logic       grant_take;
	logic       grant_done;
	// Granted beat stream
	logic       beat_valid;
	logic       beat_last;
	beat_t      beat_data;
	port_idx_t  src;
	logic       fwd_ready;
	// Table request and result
	logic       lkup;
	mac_t       src_mac;
	mac_t       dst_mac;
	logic       hit;
	port_idx_t  hit_port;
	port_mask_t mask;

	rx_port_arb u_rx_port_arb (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_rx_valid(i_rx_valid),
		.o_rx_ready(o_rx_ready), .i_rx_data(i_rx_data), .i_rx_last(i_rx_last),
		.i_grant_take(grant_take), .i_grant_done(grant_done), .i_fwd_ready(fwd_ready),
		.o_req(req), .o_valid(beat_valid), .o_last(beat_last), .o_data(beat_data),
		.o_src(src));

	mac_route_table u_mac_route_table (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_lkup(lkup),
		.i_src_mac(src_mac), .i_dst_mac(dst_mac), .i_src(src), .o_hit(hit),
		.o_port(hit_port));

	fwd_ctrl u_fwd_ctrl (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(req),
		.i_beat_valid(beat_valid), .i_beat_last(beat_last), .i_beat_take(fwd_ready),
		.i_first_data(beat_data), .i_src(src), .i_hit(hit), .i_port(hit_port),
		.o_grant_take(grant_take), .o_grant_done(grant_done), .o_lkup(lkup),
		.o_src_mac(src_mac), .o_dst_mac(dst_mac), .o_mask(mask));

	tx_fanout u_tx_fanout (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(beat_valid),
		.i_last(beat_last), .i_data(beat_data), .i_mask(mask), .o_ready(fwd_ready),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_last(o_tx_last),
		.i_tx_ready(i_tx_ready));

endmodule

`default_nettype wire

// ==== tests/tb_frames.svh ====
/* Frame rows: source port, source MAC, destination MAC, beat count (1 to 8), expected mask.
   Rows depend on their order, since each one learns into the table for the rows after it. */
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

typedef struct packed {
	port_idx_t  src;
	mac_t       smac;
	mac_t       dmac;
	int         nbeat;
	port_mask_t exp;
} frame_t;

localparam int NFRM = 24;

frame_t frames [NFRM];

task automatic load_frames();
	// Unknown destination floods, then learned entries route to one port
	frames[0]  = '{2'd0, 48'h0200_0000_0001, 48'h0200_0000_0002, 3, 4'b1110};
	frames[1]  = '{2'd1, 48'h0200_0000_0002, 48'h0200_0000_0001, 2, 4'b0001};
	frames[2]  = '{2'd0, 48'h0200_0000_0001, 48'h0200_0000_0002, 4, 4'b0010};
	frames[3]  = '{2'd2, 48'h0200_0000_0003, 48'h0200_0000_0004, 1, 4'b1011};
	// Destination learned on the source port is dropped, the next frame still passes
	frames[4]  = '{2'd0, 48'h0200_0000_0005, 48'h0200_0000_0001, 2, 4'b0000};
	frames[5]  = '{2'd3, 48'h0200_0000_0004, 48'h0200_0000_0003, 2, 4'b0100};
	// Broadcast address gets learned as a source, yet frames to it still flood
	frames[6]  = '{2'd3, 48'hffff_ffff_ffff, 48'h0200_0000_0002, 1, 4'b0010};
	frames[7]  = '{2'd1, 48'h0200_0000_0002, 48'hffff_ffff_ffff, 3, 4'b1101};
	frames[8]  = '{2'd0, 48'h0200_0000_0001, 48'hffff_ffff_ffff, 1, 4'b1110};
	// Longer frames under random back-pressure
	frames[9]  = '{2'd2, 48'h0200_0000_0003, 48'h0200_0000_0004, 5, 4'b1000};
	frames[10] = '{2'd3, 48'h0200_0000_0004, 48'h0200_0000_0006, 4, 4'b0111};
	frames[11] = '{2'd1, 48'h0200_0000_0002, 48'h0200_0000_0003, 6, 4'b0100};
	// Eight new sources wrap the replacement pointer
	frames[12] = '{2'd1, 48'h0200_0000_0006, 48'h0200_0000_0001, 2, 4'b0001};
	frames[13] = '{2'd2, 48'h0200_0000_0007, 48'h0200_0000_0006, 1, 4'b0010};
	frames[14] = '{2'd3, 48'h0200_0000_0008, 48'h0200_0000_0002, 3, 4'b0010};
	frames[15] = '{2'd2, 48'h0200_0000_0003, 48'h0200_0000_0001, 2, 4'b1011};
	frames[16] = '{2'd0, 48'h0200_0000_0009, 48'h0200_0000_0008, 2, 4'b1000};
	frames[17] = '{2'd1, 48'h0200_0000_000a, 48'h0200_0000_0002, 2, 4'b1101};
	frames[18] = '{2'd3, 48'h0200_0000_000b, 48'h0200_0000_0003, 1, 4'b0111};
	frames[19] = '{2'd0, 48'h0200_0000_000c, 48'h0200_0000_000a, 3, 4'b0010};
	frames[20] = '{2'd2, 48'h0200_0000_000d, 48'h0200_0000_000b, 2, 4'b1000};
	// Replaced MACs flood again, a relearned one routes again
	frames[21] = '{2'd1, 48'h0200_0000_0006, 48'h0200_0000_0004, 4, 4'b1101};
	frames[22] = '{2'd0, 48'h0200_0000_0001, 48'h0200_0000_000d, 2, 4'b0100};
	frames[23] = '{2'd3, 48'h0200_0000_0008, 48'h0200_0000_0001, 3, 4'b0001};
endtask

`endif

// ==== tests/tb_route_core.sv ====
/* Frames run one at a time and drain before the next, so every output beat belongs to
   the current frame. The table model assumes the DUT sees no other traffic. */
`timescale 1ns/1ps
`default_nettype none

`include "route_core_cfg.svh"

module tb_route_core
	import route_core_pkg::*;
();

	localparam int PERIOD = 40;
	localparam int NTBL   = 1 << `RC_LGTBL;
	localparam int MAXB   = 8;

	logic       clk;
	logic       rst_n;
	port_mask_t rx_valid;
	port_mask_t rx_ready;
	beat_t      rx_data [`RC_NETH];
	port_mask_t rx_last;
	port_mask_t tx_valid;
	port_mask_t tx_ready;
	beat_t      tx_data;
	logic       tx_last;

	`include "tb_frames.svh"

	// Model of the learned table
	logic      mdl_vld  [NTBL];
	mac_t      mdl_mac  [NTBL];
	port_idx_t mdl_port [NTBL];
	tbl_idx_t  mdl_ptr;

	// Current frame and what each port has taken of it
	beat_t      beats [MAXB];
	int         nbeat;
	int         got [`RC_NETH];
	port_mask_t rcv;

	int seed    = 32'h2059;
	int errors  = 0;
	int checked = 0;

	route_core i_route_core (.i_clk(clk), .i_rst_n(rst_n), .i_rx_valid(rx_valid),
		.o_rx_ready(rx_ready), .i_rx_data(rx_data), .i_rx_last(rx_last),
		.o_tx_valid(tx_valid), .i_tx_ready(tx_ready), .o_tx_data(tx_data),
		.o_tx_last(tx_last));

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Run limit scales with the number of frame rows
	initial
	begin
		#(NFRM * 200 * PERIOD);
		$display("Timeout: frames did not drain within %0d cycles", NFRM * 200);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_mask(input string name, input port_mask_t act, input port_mask_t exp);
		if (act !== exp)
		begin
			errors++;
			$display("ERR %0t %s got %b expected %b", $time, name, act, exp);
		end
	endtask

	task automatic check_beat(input string name, input beat_t act, input beat_t exp);
		if (act !== exp)
		begin
			errors++;
			$display("ERR %0t %s got %h expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_last(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			errors++;
			$display("ERR %0t %s got %b expected %b", $time, name, act, exp);
		end
	endtask

	// Beats taken at this edge, values from before the edge
	task automatic observe();
		for (int p = 0; p < `RC_NETH; p++)
		begin
			if (tx_valid[p] && tx_ready[p])
			begin
				rcv[p] = 1'b1;
				if (got[p] >= nbeat)
				begin
					errors++;
					$display("Port %0d received more beats than the frame holds", p);
				end
				else
				begin
					check_beat($sformatf("o_tx_data[%0d]", p), tx_data, beats[got[p]]);
					check_last($sformatf("o_tx_last[%0d]", p), tx_last, got[p] == nbeat - 1);
					checked++;
				end
				got[p]++;
			end
		end
	endtask

	// One clock: watch the outputs, then draw a new ready pattern
	task automatic tick();
		@(posedge clk);
		observe();
		tx_ready <= port_mask_t'($random(seed));
	endtask

	////////////////////////////////////////////////////////////
	// Table model, lookup before learn
	////////////////////////////////////////////////////////////
	task automatic predict(input frame_t fr, output port_mask_t m);
		logic      hit;
		port_idx_t hp;
		int        si;
		hit = 1'b0;
		hp  = '0;
		si  = -1;
		for (int e = 0; e < NTBL; e++)
		begin
			if (mdl_vld[e] && mdl_mac[e] == fr.dmac)
			begin
				hit = 1'b1;
				hp  = mdl_port[e];
			end
			if (mdl_vld[e] && mdl_mac[e] == fr.smac)
				si = e;
		end
		// Broadcast or unknown floods, a hit on the source drops
		if (fr.dmac == '1 || !hit)
			m = ~(port_mask_t'(1) << fr.src);
		else if (hp == fr.src)
			m = '0;
		else
			m = port_mask_t'(1) << hp;
		if (si >= 0)
			mdl_port[si] = fr.src;
		else
		begin
			// New source takes the oldest slot
			mdl_vld[mdl_ptr]  = 1'b1;
			mdl_mac[mdl_ptr]  = fr.smac;
			mdl_port[mdl_ptr] = fr.src;
			mdl_ptr           = mdl_ptr + 1'b1;
		end
	endtask

	task automatic run_frame(input int f);
		frame_t     fr;
		port_mask_t pred;
		port_mask_t smask;
		int         b;
		fr = frames[f];
		predict(fr, pred);
		if (pred !== fr.exp)
		begin
			errors++;
			$display("Frame %0d: model predicts mask %b, table row says %b", f, pred, fr.exp);
		end
		nbeat = fr.nbeat;
		for (b = 0; b < nbeat; b++)
			beats[b] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		// Both MACs ride in the first beat
		beats[0][`RC_DST_LSB +: `RC_MACW] = fr.dmac;
		beats[0][`RC_SRC_LSB +: `RC_MACW] = fr.smac;
		rcv = '0;
		for (int p = 0; p < `RC_NETH; p++)
			got[p] = 0;
		smask = port_mask_t'(1) << fr.src;
		b = 0;
		while (b < nbeat)
		begin
			rx_valid        <= smask;
			rx_data[fr.src] <= beats[b];
			rx_last         <= (b == nbeat - 1) ? smask : '0;
			tick();
			if (rx_ready[fr.src])
				b++;
		end
		rx_valid <= '0;
		rx_last  <= '0;
		// Last beat still sits in the output register
		tick();
		while (tx_valid != '0)
			tick();
		check_mask("o_tx_valid", rcv, pred);
		for (int p = 0; p < `RC_NETH; p++)
		begin
			if (pred[p] && got[p] != nbeat)
			begin
				errors++;
				$display("Frame %0d: port %0d received %0d of %0d beats", f, p, got[p], nbeat);
			end
		end
	endtask

	initial
	begin
		rst_n    <= 1'b0;
		rx_valid <= '0;
		rx_last  <= '0;
		tx_ready <= '0;
		for (int p = 0; p < `RC_NETH; p++)
		begin
			rx_data[p] <= '0;
			got[p] = 0;
		end
		for (int e = 0; e < NTBL; e++)
			mdl_vld[e] = 1'b0;
		mdl_ptr = '0;
		nbeat   = 0;
		rcv     = '0;
		load_frames();
		repeat (4) tick();
		rst_n <= 1'b1;
		tick();
		for (int f = 0; f < NFRM; f++)
			run_frame(f);
		$display("Summary: %0d frames, %0d beats checked, %0d errors", NFRM, checked, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== route_core.f ====
+incdir+design
+incdir+tests
design/route_core_pkg.sv
design/rx_port_arb.sv
design/mac_route_table.sv
design/fwd_ctrl.sv
design/tx_fanout.sv
design/route_core.sv
tests/tb_route_core.sv

// ==== Makefile ====
# Verilator build and run of the route_core testbench
TOP = tb_route_core

sim:
	verilator --binary --timing --assert -f route_core.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean
